// ==== hw/execute_alu.sv ====
/* execute stage: id/ex register, operand forwarding and the alu
   the forwarded rt value doubles as the store data */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module execute_alu (
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  mips_pkg::instr_t            id_instr,
    input  logic                        reg_write,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        alu_src_imm,
    input  mips_pkg::alu_op_t           alu_op,
    input  logic [`MIPS_DATA_W-1:0]     rs_data,
    input  logic [`MIPS_DATA_W-1:0]     rt_data,
    input  logic [`MIPS_DATA_W-1:0]     imm_ext,
    input  logic [`MIPS_REG_ADDR_W-1:0] dest,
    input  mips_pkg::fwd_sel_t          fwd_a,
    input  mips_pkg::fwd_sel_t          fwd_b,
    input  logic [`MIPS_DATA_W-1:0]     mem_alu_result,
    input  logic [`MIPS_DATA_W-1:0]     wb_data,
    output logic [`MIPS_REG_ADDR_W-1:0] ex_rs,
    output logic [`MIPS_REG_ADDR_W-1:0] ex_rt,
    output logic                        ex_reg_write,
    output logic                        ex_mem_read,
    output logic                        ex_mem_write,
    output logic [`MIPS_REG_ADDR_W-1:0] ex_dest,
    output logic [`MIPS_DATA_W-1:0]     ex_result,
    output logic [`MIPS_DATA_W-1:0]     ex_store_data
);
    mips_pkg::instr_t        ex_instr;
    mips_pkg::alu_op_t       ex_alu_op;
    logic                    ex_alu_src_imm;
    logic [`MIPS_DATA_W-1:0] ex_rs_val;
    logic [`MIPS_DATA_W-1:0] ex_rt_val;
    logic [`MIPS_DATA_W-1:0] ex_imm;
    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] op_b;

    function automatic logic [`MIPS_DATA_W-1:0] fwd_mux(
        input mips_pkg::fwd_sel_t      sel,
        input logic [`MIPS_DATA_W-1:0] reg_val
    );
        case (sel)
            mips_pkg::FWD_MEM: return mem_alu_result;
            mips_pkg::FWD_WB:  return wb_data;
            default:           return reg_val;
        endcase
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_instr     <= '0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_alu_op    <= mips_pkg::ALU_NOP;
        end
        else
        begin
            ex_instr     <= id_instr;
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_alu_op    <= alu_op;
        end
        ex_alu_src_imm <= alu_src_imm;
        ex_rs_val      <= rs_data;
        ex_rt_val      <= rt_data;
        ex_imm         <= imm_ext;
        ex_dest        <= dest;
    end

    assign ex_rs = ex_instr.r.rs;
    assign ex_rt = ex_instr.i.rt;

    always_comb
    begin
        op_a          = fwd_mux(fwd_a, ex_rs_val);
        ex_store_data = fwd_mux(fwd_b, ex_rt_val);
        op_b          = ex_alu_src_imm ? ex_imm : ex_store_data;
    end

    always_comb
    begin
        ex_result = '0;
        case (ex_alu_op)
            mips_pkg::ALU_ADD: ex_result = op_a + op_b;
            mips_pkg::ALU_SUB: ex_result = op_a - op_b;
            mips_pkg::ALU_AND: ex_result = op_a & op_b;
            mips_pkg::ALU_OR:  ex_result = op_a | op_b;
            mips_pkg::ALU_SLT: ex_result[0] = $signed(op_a) < $signed(op_b);  // signed compare
            default:           ex_result = '0;
        endcase
    end

endmodule

// ==== hw/fetch_decode.sv ====
/* fetch and decode: pc counter, if/id register and the register file with
   write-through, sign extension and the destination register choice */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module fetch_decode (
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  logic [`MIPS_DATA_W-1:0]     instr,
    input  logic                        dest_rd,
    input  logic                        wb_en,
    input  logic [`MIPS_REG_ADDR_W-1:0] wb_reg,
    input  logic [`MIPS_DATA_W-1:0]     wb_data,
    output logic [`MIPS_DATA_W-1:0]     pc,
    output mips_pkg::instr_t            id_instr,
    output logic [`MIPS_DATA_W-1:0]     rs_data,
    output logic [`MIPS_DATA_W-1:0]     rt_data,
    output logic [`MIPS_DATA_W-1:0]     imm_ext,
    output logic [`MIPS_REG_ADDR_W-1:0] dest
);
    localparam int NUM_REGS = 2 ** `MIPS_REG_ADDR_W;

    logic [`MIPS_DATA_W-1:0] regs [NUM_REGS];

    // $0 is hardwired; a same-cycle write is seen by the read
    function automatic logic [`MIPS_DATA_W-1:0] rf_read(
        input logic [`MIPS_REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (wb_en && wb_reg == addr)
            return wb_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc       <= '0;
            id_instr <= '0;                 // zero word is a no-op
        end
        else
        begin
            pc       <= pc + `MIPS_DATA_W'(4);
            id_instr <= instr;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_reg != '0)
        begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_comb
    begin
        rs_data = rf_read(id_instr.r.rs);
        rt_data = rf_read(id_instr.r.rt);
    end

    assign imm_ext = {{(`MIPS_DATA_W-16){id_instr.i.imm[15]}}, id_instr.i.imm};
    assign dest    = dest_rd ? id_instr.r.rd : id_instr.i.rt;  // r-type writes rd

endmodule

// ==== hw/memory_writeback.sv ====
/* memory and writeback: ex/mem register, word-addressed data memory,
   mem/wb register and the writeback mux toward the register file */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module memory_writeback (
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  logic                        ex_reg_write,
    input  logic                        ex_mem_read,
    input  logic                        ex_mem_write,
    input  logic [`MIPS_REG_ADDR_W-1:0] ex_dest,
    input  logic [`MIPS_DATA_W-1:0]     ex_result,
    input  logic [`MIPS_DATA_W-1:0]     ex_store_data,
    output logic [`MIPS_DATA_W-1:0]     mem_alu_result,
    output logic [`MIPS_REG_ADDR_W-1:0] mem_dest,
    output logic                        mem_reg_write,
    output logic                        mem_load,
    output logic [`MIPS_REG_ADDR_W-1:0] wb_dest,
    output logic                        wb_en,
    output logic [`MIPS_REG_ADDR_W-1:0] wb_reg,
    output logic [`MIPS_DATA_W-1:0]     wb_data
);
    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_DATA_W-1:0] dmem [`MIPS_DMEM_WORDS];
    logic                    mem_store;
    logic [`MIPS_DATA_W-1:0] mem_store_data;
    logic [DMEM_AW-1:0]      mem_index;
    logic                    wb_write;
    logic                    wb_load;
    logic [`MIPS_DATA_W-1:0] wb_alu_result;
    logic [`MIPS_DATA_W-1:0] wb_load_data;

    assign mem_index = mem_alu_result[DMEM_AW+1:2];  // upper address bits ignored

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            wb_write      <= 1'b0;
            wb_load       <= 1'b0;
        end
        else
        begin
            mem_reg_write <= ex_reg_write;
            mem_load      <= ex_mem_read;
            mem_store     <= ex_mem_write;
            wb_write      <= mem_reg_write;
            wb_load       <= mem_load;
        end
        mem_dest       <= ex_dest;
        mem_alu_result <= ex_result;
        mem_store_data <= ex_store_data;
        wb_dest        <= mem_dest;
        wb_alu_result  <= mem_alu_result;
        wb_load_data   <= dmem[mem_index];             // read is combinational in mem
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (mem_store)
        begin
            dmem[mem_index] <= mem_store_data;         // store lands at end of mem
        end
    end

    assign wb_en   = wb_write && wb_dest != '0;        // $0 never written back
    assign wb_reg  = wb_dest;
    assign wb_data = wb_load ? wb_load_data : wb_alu_result;

endmodule

// ==== hw/mips_cfg.svh ====
/* widths, memory depth and instruction encodings for the mips pipeline
   include wherever a width or an opcode is needed */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_DATA_W      32        // data and instruction word
`define MIPS_REG_ADDR_W  5         // register index
`define MIPS_DMEM_WORDS  64        // indexed by address bits 7:2

// opcodes
`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SW       6'h2B

// r-type funct codes
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_SLT      6'h2A

`endif

// ==== hw/mips_core.sv ====
/* top of the five stage pipeline; the program comes in through the fetch port
   and every register write leaves through the wb ports */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_core (
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    output logic [`MIPS_DATA_W-1:0]     pc,
    input  logic [`MIPS_DATA_W-1:0]     instr,
    output logic                        wb_en,
    output logic [`MIPS_REG_ADDR_W-1:0] wb_reg,
    output logic [`MIPS_DATA_W-1:0]     wb_data
);
    mips_pkg::instr_t            id_instr;
    logic                        reg_write;
    logic                        mem_read;
    logic                        mem_write;
    logic                        alu_src_imm;
    logic                        dest_rd;
    mips_pkg::alu_op_t           alu_op;
    mips_pkg::fwd_sel_t          fwd_a;
    mips_pkg::fwd_sel_t          fwd_b;
    logic [`MIPS_DATA_W-1:0]     rs_data;
    logic [`MIPS_DATA_W-1:0]     rt_data;
    logic [`MIPS_DATA_W-1:0]     imm_ext;
    logic [`MIPS_REG_ADDR_W-1:0] dest;
    logic [`MIPS_REG_ADDR_W-1:0] ex_rs;
    logic [`MIPS_REG_ADDR_W-1:0] ex_rt;
    logic                        ex_reg_write;
    logic                        ex_mem_read;
    logic                        ex_mem_write;
    logic [`MIPS_REG_ADDR_W-1:0] ex_dest;
    logic [`MIPS_DATA_W-1:0]     ex_result;
    logic [`MIPS_DATA_W-1:0]     ex_store_data;
    logic [`MIPS_DATA_W-1:0]     mem_alu_result;
    logic [`MIPS_REG_ADDR_W-1:0] mem_dest;
    logic                        mem_reg_write;
    logic                        mem_load;
    logic [`MIPS_REG_ADDR_W-1:0] wb_dest;

    pipe_control ctrl (
        .id_instr      (id_instr),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .mem_load      (mem_load),
        .wb_dest       (wb_dest),
        .wb_reg_write  (wb_en),            // already low for $0
        .reg_write     (reg_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_src_imm   (alu_src_imm),
        .dest_rd       (dest_rd),
        .alu_op        (alu_op),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    fetch_decode fd (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .instr     (instr),
        .dest_rd   (dest_rd),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .pc        (pc),
        .id_instr  (id_instr),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .imm_ext   (imm_ext),
        .dest      (dest)
    );

    execute_alu ex (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .id_instr       (id_instr),
        .reg_write      (reg_write),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .alu_src_imm    (alu_src_imm),
        .alu_op         (alu_op),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .imm_ext        (imm_ext),
        .dest           (dest),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .mem_alu_result (mem_alu_result),
        .wb_data        (wb_data),
        .ex_rs          (ex_rs),
        .ex_rt          (ex_rt),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_dest        (ex_dest),
        .ex_result      (ex_result),
        .ex_store_data  (ex_store_data)
    );

    memory_writeback mw (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_dest        (ex_dest),
        .ex_result      (ex_result),
        .ex_store_data  (ex_store_data),
        .mem_alu_result (mem_alu_result),
        .mem_dest       (mem_dest),
        .mem_reg_write  (mem_reg_write),
        .mem_load       (mem_load),
        .wb_dest        (wb_dest),
        .wb_en          (wb_en),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data)
    );

endmodule

// ==== hw/mips_pkg.sv ====
/* shared types of the pipeline: the instruction word seen in r and i format,
   the alu operation and the execute operand source */
`include "mips_cfg.svh"

package mips_pkg;

    typedef struct packed
    {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [4:0]                  shamt;
        logic [5:0]                  funct;
    } r_fmt_t;

    typedef struct packed
    {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [15:0]                 imm;
    } i_fmt_t;

    // one word, two views
    typedef union packed
    {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_NOP
    } alu_op_t;

    typedef enum logic [1:0]
    {
        FWD_NONE,  // register file value
        FWD_MEM,   // ex/mem alu result
        FWD_WB     // mem/wb writeback value
    } fwd_sel_t;

endpackage

// ==== hw/pipe_control.sv ====
/* main decoder for the instruction in decode, plus the operand source
   choice for the instruction in execute; purely combinational */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module pipe_control (
    input  mips_pkg::instr_t            id_instr,
    input  logic [`MIPS_REG_ADDR_W-1:0] ex_rs,
    input  logic [`MIPS_REG_ADDR_W-1:0] ex_rt,
    input  logic [`MIPS_REG_ADDR_W-1:0] mem_dest,
    input  logic                        mem_reg_write,
    input  logic                        mem_load,
    input  logic [`MIPS_REG_ADDR_W-1:0] wb_dest,
    input  logic                        wb_reg_write,
    output logic                        reg_write,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        alu_src_imm,
    output logic                        dest_rd,
    output mips_pkg::alu_op_t           alu_op,
    output mips_pkg::fwd_sel_t          fwd_a,
    output mips_pkg::fwd_sel_t          fwd_b
);

    // nearest older writer wins; a load in mem has no data yet
    function automatic mips_pkg::fwd_sel_t pick_src(
        input logic [`MIPS_REG_ADDR_W-1:0] src
    );
        if (mem_reg_write && !mem_load && mem_dest != '0 && mem_dest == src)
            return mips_pkg::FWD_MEM;
        else if (wb_reg_write && wb_dest != '0 && wb_dest == src)
            return mips_pkg::FWD_WB;
        else
            return mips_pkg::FWD_NONE;
    endfunction

    always_comb
    begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        dest_rd     = 1'b0;
        alu_op      = mips_pkg::ALU_NOP;  // unknown encodings stay a no-op

        case (id_instr.r.opcode)
            `MIPS_OP_RTYPE:
            begin
                dest_rd   = 1'b1;
                reg_write = 1'b1;
                case (id_instr.r.funct)
                    `MIPS_FN_ADD: alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUB: alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND: alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:  alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_SLT: alu_op = mips_pkg::ALU_SLT;
                    default:      reg_write = 1'b0;  // includes the all-zero word
                endcase
            end
            `MIPS_OP_ADDI:
            begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;
            end
            `MIPS_OP_LW:
            begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;  // base plus offset
            end
            `MIPS_OP_SW:
            begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;
            end
            default:
            begin
                alu_op = mips_pkg::ALU_NOP;
            end
        endcase
    end

    always_comb
    begin
        fwd_a = pick_src(ex_rs);
        fwd_b = pick_src(ex_rt);
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/mips_pkg.sv
hw/pipe_control.sv
hw/fetch_decode.sv
hw/execute_alu.sv
hw/memory_writeback.sv
hw/mips_core.sv
verification/mips_core_assertions.sv
verification/mips_core_tb.sv

// ==== verification/mips_core_assertions.sv ====
/* concurrent checks on the pipeline top level, bound into mips_core
   covers reset quiet time, pc stepping and writeback to $0 */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_core_assertions (
    input logic                        SYS_clk,
    input logic                        SYS_reset,
    input logic [`MIPS_DATA_W-1:0]     pc,
    input logic                        wb_en,
    input logic [`MIPS_REG_ADDR_W-1:0] wb_reg
);

    // pipeline registers hold the no-op word through reset
    assert property (@(posedge SYS_clk) SYS_reset |=> !wb_en)
        else $error("wb_en went high while reset was applied");

    // first instruction needs four edges to reach writeback
    assert property (@(posedge SYS_clk) $fell(SYS_reset) |-> !wb_en [*4])
        else $error("wb_en went high within four cycles of reset release");

    assert property (@(posedge SYS_clk) !SYS_reset |=> pc == $past(pc) + `MIPS_DATA_W'(4))
        else $error("pc did not advance by 4");

    assert property (@(posedge SYS_clk) wb_en |-> wb_reg != '0)
        else $error("writeback to register zero");  // gated in mem/wb

endmodule

bind mips_core mips_core_assertions checks (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg)
);

// ==== verification/mips_core_tb.sv ====
/* testbench for mips_core: supplies a directed and random program through
   the fetch port and checks each writeback against an isa model */
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_core_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_COUNT = 300;

    logic                        SYS_clk   = 1'b0;
    logic                        SYS_reset = 1'b1;
    logic [`MIPS_DATA_W-1:0]     instr     = '0;
    logic [`MIPS_DATA_W-1:0]     pc;
    logic                        wb_en;
    logic [`MIPS_REG_ADDR_W-1:0] wb_reg;
    logic [`MIPS_DATA_W-1:0]     wb_data;

    logic [`MIPS_DATA_W-1:0]     prog [$];
    string                       prog_sect [$];     // section name per word
    string                       cur_sect;
    logic [`MIPS_REG_ADDR_W-1:0] exp_reg [$];
    logic [`MIPS_DATA_W-1:0]     exp_val [$];
    string                       exp_name [$];
    logic [`MIPS_DATA_W-1:0]     ref_regs [32];
    logic [`MIPS_DATA_W-1:0]     ref_mem [`MIPS_DMEM_WORDS];
    logic [31:0]                 lcg_state   = 32'd51;
    int                          reset_cnt   = 0;
    int                          cycle_limit = 0;

    mips_core DUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .pc        (pc),
        .instr     (instr),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    always #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd,
                                               input int rs, input int rt);
        mips_pkg::instr_t w;
        w          = '0;
        w.r.opcode = `MIPS_OP_RTYPE;
        w.r.rs     = `MIPS_REG_ADDR_W'(rs);
        w.r.rt     = `MIPS_REG_ADDR_W'(rt);
        w.r.rd     = `MIPS_REG_ADDR_W'(rd);
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt,
                                               input int rs, input int imm);
        mips_pkg::instr_t w;
        w          = '0;
        w.i.opcode = op;
        w.i.rs     = `MIPS_REG_ADDR_W'(rs);
        w.i.rt     = `MIPS_REG_ADDR_W'(rt);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    function automatic logic [5:0] alu_funct(input int k);
        case (k)
            0:       return `MIPS_FN_ADD;
            1:       return `MIPS_FN_SUB;
            2:       return `MIPS_FN_AND;
            3:       return `MIPS_FN_OR;
            default: return `MIPS_FN_SLT;
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input int idx);
        if (idx < prog.size())
            return prog[idx];
        else
            return '0;
    endfunction

    task automatic append_word(input logic [31:0] w);
        prog.push_back(w);
        prog_sect.push_back(cur_sect);
    endtask

    // registers 0..7 only, so dependencies are frequent
    task automatic random_section(input int count);
        int kind;
        int rs;
        int rt;
        int rd;
        int imm;
        int load_dest;
        load_dest = -1;
        for (int i = 0; i < count; i++)
        begin
            kind = (lcg_next() >> 16) % 8;
            rs   = (lcg_next() >> 16) % 8;
            rt   = (lcg_next() >> 16) % 8;
            rd   = (lcg_next() >> 16) % 8;
            imm  = (lcg_next() >> 16) & 16'hFFFF;
            if (rs == load_dest)
                rs = (rs + 1) % 8;              // no load-use in the next slot
            if (rt == load_dest)
                rt = (rt + 1) % 8;
            case (kind)
                5:       append_word(itype_word(`MIPS_OP_ADDI, rt, rs, imm));
                6:       append_word(itype_word(`MIPS_OP_LW, rt, rs, imm));
                7:       append_word(itype_word(`MIPS_OP_SW, rt, rs, imm));
                default: append_word(rtype_word(alu_funct(kind), rd, rs, rt));
            endcase
            load_dest = (kind == 6) ? rt : -1;
        end
    endtask

    task automatic build_program();
        cur_sect = "alu_basic";
        append_word(itype_word(`MIPS_OP_ADDI, 1, 0, 25));
        append_word(itype_word(`MIPS_OP_ADDI, 2, 0, -7));
        append_word(itype_word(`MIPS_OP_ADDI, 3, 0, 100));
        append_word(itype_word(`MIPS_OP_ADDI, 4, 0, -300));
        append_word('0);
        append_word('0);
        append_word('0);                         // presets settle in the register file
        append_word(rtype_word(`MIPS_FN_ADD, 5, 1, 2));
        append_word(rtype_word(`MIPS_FN_SUB, 6, 1, 3));
        append_word(rtype_word(`MIPS_FN_AND, 7, 3, 4));
        append_word(rtype_word(`MIPS_FN_OR, 8, 1, 4));
        append_word(rtype_word(`MIPS_FN_SLT, 9, 2, 1));
        append_word(rtype_word(`MIPS_FN_SLT, 10, 1, 2));
        append_word(rtype_word(`MIPS_FN_SLT, 11, 4, 2));   // both negative
        append_word(rtype_word(`MIPS_FN_SLT, 12, 2, 4));

        cur_sect = "addi_sext";
        append_word(itype_word(`MIPS_OP_ADDI, 13, 0, -1));
        append_word(itype_word(`MIPS_OP_ADDI, 14, 3, -32768));
        append_word(itype_word(`MIPS_OP_ADDI, 15, 2, -1000));
        append_word(itype_word(`MIPS_OP_ADDI, 16, 0, 32767));

        cur_sect = "forwarding";
        append_word(itype_word(`MIPS_OP_ADDI, 17, 0, 5));
        append_word(rtype_word(`MIPS_FN_ADD, 18, 17, 1));  // rs distance 1
        append_word(rtype_word(`MIPS_FN_SUB, 19, 2, 17));  // rt distance 2
        append_word(rtype_word(`MIPS_FN_OR, 20, 3, 17));   // rt distance 3
        append_word(itype_word(`MIPS_OP_ADDI, 21, 0, 9));
        append_word(rtype_word(`MIPS_FN_SUB, 22, 1, 21));  // rt distance 1
        append_word(rtype_word(`MIPS_FN_AND, 23, 21, 4));  // rs distance 2
        append_word(rtype_word(`MIPS_FN_SLT, 24, 21, 22)); // rs distance 3
        append_word(itype_word(`MIPS_OP_ADDI, 25, 0, 1));
        append_word(itype_word(`MIPS_OP_ADDI, 25, 25, 2));
        append_word(rtype_word(`MIPS_FN_ADD, 26, 25, 25)); // newest $25 must win

        cur_sect = "load_store";
        append_word(itype_word(`MIPS_OP_SW, 5, 0, 0));
        append_word(itype_word(`MIPS_OP_SW, 6, 0, 4));
        append_word(itype_word(`MIPS_OP_SW, 11, 3, 8));    // address 108
        append_word(itype_word(`MIPS_OP_LW, 27, 0, 0));
        append_word(itype_word(`MIPS_OP_LW, 28, 0, 4));
        append_word(itype_word(`MIPS_OP_LW, 29, 0, 108));
        append_word(itype_word(`MIPS_OP_LW, 30, 0, 40));   // never written
        append_word(itype_word(`MIPS_OP_LW, 31, 0, 260));  // wraps to word 1
        append_word(itype_word(`MIPS_OP_SW, 13, 0, 12));
        append_word(itype_word(`MIPS_OP_LW, 27, 0, 12));
        append_word(itype_word(`MIPS_OP_LW, 28, 3, 8));
        append_word(itype_word(`MIPS_OP_ADDI, 29, 0, 3));
        append_word(rtype_word(`MIPS_FN_ADD, 30, 28, 28)); // load at distance 2
        append_word(itype_word(`MIPS_OP_ADDI, 31, 0, 77));
        append_word(itype_word(`MIPS_OP_SW, 31, 0, 16));   // store data forwarded
        append_word(itype_word(`MIPS_OP_LW, 27, 0, 16));
        append_word(itype_word(`MIPS_OP_ADDI, 29, 0, 20));
        append_word(itype_word(`MIPS_OP_SW, 2, 29, 4));    // base forwarded
        append_word(itype_word(`MIPS_OP_LW, 28, 0, 24));

        cur_sect = "zero_reg";
        append_word(itype_word(`MIPS_OP_ADDI, 0, 0, 55));
        append_word(rtype_word(`MIPS_FN_ADD, 9, 0, 0));
        append_word(rtype_word(`MIPS_FN_ADD, 0, 1, 2));
        append_word(rtype_word(`MIPS_FN_ADD, 10, 0, 1));
        append_word(rtype_word(6'h21, 11, 1, 2));            // funct not supported
        append_word(rtype_word(`MIPS_FN_OR, 11, 11, 0));
        append_word(itype_word(`MIPS_OP_LW, 0, 0, 0));
        append_word('0);
        append_word(rtype_word(`MIPS_FN_ADD, 12, 0, 5));

        cur_sect = "random";
        random_section(RANDOM_COUNT);

        cur_sect = "drain";
        for (int i = 0; i < 5; i++)
            append_word('0);
    endtask

    // isa semantics of one program word, in program order
    function automatic void isa_exec(input int idx);
        mips_pkg::instr_t            w;
        logic [`MIPS_DATA_W-1:0]     a;
        logic [`MIPS_DATA_W-1:0]     b;
        logic [`MIPS_DATA_W-1:0]     imm;
        logic [`MIPS_DATA_W-1:0]     addr;
        logic [`MIPS_DATA_W-1:0]     res;
        logic                        wr;
        logic [`MIPS_REG_ADDR_W-1:0] dst;
        w    = prog[idx];
        a    = ref_regs[w.r.rs];
        b    = ref_regs[w.r.rt];
        imm  = {{16{w.i.imm[15]}}, w.i.imm};
        addr = a + imm;
        res  = '0;
        wr   = 1'b0;
        dst  = w.i.rt;
        case (w.r.opcode)
            `MIPS_OP_RTYPE:
            begin
                dst = w.r.rd;
                wr  = 1'b1;
                case (w.r.funct)
                    `MIPS_FN_ADD: res = a + b;
                    `MIPS_FN_SUB: res = a - b;
                    `MIPS_FN_AND: res = a & b;
                    `MIPS_FN_OR:  res = a | b;
                    `MIPS_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:      wr = 1'b0;
                endcase
            end
            `MIPS_OP_ADDI:
            begin
                wr  = 1'b1;
                res = a + imm;
            end
            `MIPS_OP_LW:
            begin
                wr  = 1'b1;
                res = ref_mem[addr[7:2]];
            end
            `MIPS_OP_SW:
            begin
                ref_mem[addr[7:2]] = b;
            end
            default:
            begin
                wr = 1'b0;
            end
        endcase
        if (wr && dst != '0)
        begin
            ref_regs[dst] = res;
            exp_reg.push_back(dst);
            exp_val.push_back(res);
            exp_name.push_back(prog_sect[idx]);
        end
    endfunction

    task automatic run_reference();
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        foreach (ref_mem[i])
            ref_mem[i] = '0;
        for (int i = 0; i < prog.size(); i++)
            isa_exec(i);
    endtask

    // the word for the pc that this edge moves to
    always @(posedge SYS_clk)
    begin
        if (reset_cnt < RESET_CYCLES)
            reset_cnt <= reset_cnt + 1;
        SYS_reset <= (reset_cnt < RESET_CYCLES - 1);
        if (SYS_reset)
            instr <= fetch_word(0);
        else
            instr <= fetch_word(pc / 4 + 1);
    end

    always @(negedge SYS_clk)
    begin : check_writeback
        string                       name;
        logic [`MIPS_REG_ADDR_W-1:0] r;
        logic [`MIPS_DATA_W-1:0]     v;
        if (wb_en === 1'b1)
        begin
            if (exp_reg.size() == 0)
            begin
                abort_run("a register writeback appeared when none was expected");
            end
            else
            begin
                name = exp_name.pop_front();
                r    = exp_reg.pop_front();
                v    = exp_val.pop_front();
                assert (wb_reg == r)
                    else abort_run($sformatf("[FAIL] %s: wb_reg expected %0d, actual %0d",
                                             name, r, wb_reg));
                assert (wb_data == v)
                    else abort_run($sformatf("[FAIL] %s: wb_data expected 0x%08h, actual 0x%08h",
                                             name, v, wb_data));
            end
        end
    end

    initial
    begin : watchdog
        wait (cycle_limit != 0);
        #(cycle_limit * CLK_PERIOD);
        abort_run("watchdog expired before the program finished");
    end

    initial
    begin
        build_program();
        run_reference();
        cycle_limit = RESET_CYCLES + prog.size() + 20;
        wait (SYS_reset == 1'b0);
        while (pc < 4 * prog.size())
            @(negedge SYS_clk);
        @(negedge SYS_clk);
        @(negedge SYS_clk);
        if (exp_reg.size() != 0)
        begin
            abort_run($sformatf("%0d expected writebacks never appeared", exp_reg.size()));
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
